/* hdl/core_params.svh */
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// Data path width
`define XLEN 32

// Memory depths in words
`define IMEM_WORDS 64
`define DMEM_WORDS 64

// First fetch address
`define RESET_PC 32'h0000_0000

`endif

/* hdl/core_pkg.sv */
package core_pkg;

    // RV32I major opcodes
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111
    } opcode_t;

    typedef enum logic [3:0] {
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        SLL,
        SRL,
        SRA,
        SLT,
        PASS_B
    } alu_op_t;

endpackage

/* hdl/fetch_stage.sv */
`timescale 1ns/1ps
`include "core_params.svh"

module fetch_stage (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           run,
    input  logic                           imem_we,
    input  logic [$clog2(`IMEM_WORDS)-1:0] imem_addr,
    input  logic [`XLEN-1:0]               imem_data,
    input  logic                           stall,
    input  logic                           flush,
    input  logic [`XLEN-1:0]               flush_target,
    output logic                           if_valid,
    output logic [`XLEN-1:0]               if_pc,
    output logic [`XLEN-1:0]               if_inst
);

    localparam int IA_W = $clog2(`IMEM_WORDS);

    logic [`XLEN-1:0] imem [`IMEM_WORDS];
    logic [`XLEN-1:0] pc;

    // PC and IF/ID valid
    always_ff @(posedge clk) begin
        if (rst || !run) begin
            pc       <= `RESET_PC;
            if_valid <= 1'b0;
        end else if (flush) begin
            pc       <= flush_target;
            if_valid <= 1'b0;
        end else if (!stall) begin
            pc       <= pc + `XLEN'(4);
            if_valid <= 1'b1;
        end
    end

    // Load port and synchronous instruction read
    always_ff @(posedge clk) begin
        if (imem_we) begin
            imem[imem_addr] <= imem_data;
        end
        if (!stall) begin
            if_inst <= imem[pc[IA_W+1:2]];
            if_pc   <= pc;
        end
    end

endmodule

/* hdl/decode_stage.sv */
`timescale 1ns/1ps
`include "core_params.svh"

module decode_stage
    import core_pkg::*;
(
    input  logic             clk,
    input  logic             rst,
    input  logic             if_valid,
    input  logic [`XLEN-1:0] if_pc,
    input  logic [`XLEN-1:0] if_inst,
    input  logic             flush,
    input  logic             wb_we,
    input  logic [4:0]       wb_rd,
    input  logic [`XLEN-1:0] wb_data,
    output logic             stall,
    output logic             id_valid,
    output logic [`XLEN-1:0] id_pc,
    output logic [`XLEN-1:0] id_rs1_data,
    output logic [`XLEN-1:0] id_rs2_data,
    output logic [`XLEN-1:0] id_imm,
    output logic [4:0]       id_rs1,
    output logic [4:0]       id_rs2,
    output logic [4:0]       id_rd,
    output alu_op_t          id_alu_op,
    output logic             id_use_imm,
    output logic             id_use_pc,
    output logic             id_reg_write,
    output logic             id_mem_read,
    output logic             id_mem_write,
    output logic             id_branch,
    output logic [2:0]       id_funct3,
    output logic             id_jal,
    output logic             id_jalr
);

    logic [`XLEN-1:0] regs [32];

    opcode_t          opcode;
    logic [2:0]       funct3;
    logic [4:0]       rs1;
    logic [4:0]       rs2;
    logic [4:0]       rd;
    logic             alt;
    alu_op_t          f3_op;
    alu_op_t          alu_op;
    logic [`XLEN-1:0] imm_i;
    logic [`XLEN-1:0] imm_s;
    logic [`XLEN-1:0] imm_b;
    logic [`XLEN-1:0] imm_u;
    logic [`XLEN-1:0] imm_j;
    logic [`XLEN-1:0] imm;
    logic             use_imm;
    logic             use_pc;
    logic             reg_write;
    logic             mem_read;
    logic             mem_write;
    logic             branch;
    logic             jal;
    logic             jalr;

    assign opcode = opcode_t'(if_inst[6:0]);
    assign funct3 = if_inst[14:12];
    assign rs1    = if_inst[19:15];
    assign rs2    = if_inst[24:20];
    assign rd     = if_inst[11:7];

    assign imm_i = {{(`XLEN-12){if_inst[31]}}, if_inst[31:20]};
    assign imm_s = {{(`XLEN-12){if_inst[31]}}, if_inst[31:25], if_inst[11:7]};
    assign imm_b = {{(`XLEN-13){if_inst[31]}}, if_inst[31], if_inst[7],
                    if_inst[30:25], if_inst[11:8], 1'b0};
    assign imm_u = {if_inst[31:12], 12'b0};
    assign imm_j = {{(`XLEN-21){if_inst[31]}}, if_inst[31], if_inst[19:12],
                    if_inst[20], if_inst[30:21], 1'b0};

    // funct7 bit 30 picks SUB and SRA, but only shifts use it for OP_IMM
    assign alt = if_inst[30] && (opcode == OP || funct3 == 3'b101);

    always_comb begin
        case (funct3)
            3'b000:  f3_op = alt ? SUB : ADD;
            3'b001:  f3_op = SLL;
            3'b010:  f3_op = SLT;
            3'b100:  f3_op = XOR;
            3'b101:  f3_op = alt ? SRA : SRL;
            3'b110:  f3_op = OR;
            3'b111:  f3_op = AND;
            default: f3_op = ADD;
        endcase
    end

    always_comb begin
        alu_op    = ADD;
        imm       = imm_i;
        use_imm   = 1'b0;
        use_pc    = 1'b0;
        reg_write = 1'b0;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        branch    = 1'b0;
        jal       = 1'b0;
        jalr      = 1'b0;
        case (opcode)
            OP: begin
                alu_op    = f3_op;
                reg_write = 1'b1;
            end
            OP_IMM: begin
                alu_op    = f3_op;
                use_imm   = 1'b1;
                reg_write = 1'b1;
            end
            LUI: begin
                alu_op    = PASS_B;
                imm       = imm_u;
                use_imm   = 1'b1;
                reg_write = 1'b1;
            end
            AUIPC: begin
                imm       = imm_u;
                use_imm   = 1'b1;
                use_pc    = 1'b1;
                reg_write = 1'b1;
            end
            LOAD: begin
                use_imm   = 1'b1;
                reg_write = 1'b1;
                mem_read  = 1'b1;
            end
            STORE: begin
                imm       = imm_s;
                use_imm   = 1'b1;
                mem_write = 1'b1;
            end
            BRANCH: begin
                imm    = imm_b;
                branch = 1'b1;
            end
            JAL: begin
                imm       = imm_j;
                jal       = 1'b1;
                reg_write = 1'b1;
            end
            JALR: begin
                jalr      = 1'b1;
                reg_write = 1'b1;
            end
            default: ;
        endcase
    end

    // Load in ID/EX feeding the instruction being decoded
    assign stall = if_valid && id_valid && id_mem_read && id_rd != 5'd0 &&
                   (id_rd == rs1 || id_rd == rs2);

    always_ff @(posedge clk) begin
        if (wb_we && wb_rd != 5'd0) begin
            regs[wb_rd] <= wb_data;
        end
    end

    // Write-through so a same-cycle writeback is seen
    function automatic logic [`XLEN-1:0] rf_read(input logic [4:0] idx);
        if (idx == 5'd0) begin
            return '0;
        end else if (wb_we && wb_rd == idx) begin
            return wb_data;
        end
        return regs[idx];
    endfunction

    always_ff @(posedge clk) begin
        if (rst || flush || stall) begin
            id_valid <= 1'b0;
        end else begin
            id_valid <= if_valid;
        end
    end

    always_ff @(posedge clk) begin
        id_pc        <= if_pc;
        id_rs1_data  <= rf_read(rs1);
        id_rs2_data  <= rf_read(rs2);
        id_imm       <= imm;
        id_rs1       <= rs1;
        id_rs2       <= rs2;
        id_rd        <= rd;
        id_alu_op    <= alu_op;
        id_use_imm   <= use_imm;
        id_use_pc    <= use_pc;
        id_reg_write <= reg_write;
        id_mem_read  <= mem_read;
        id_mem_write <= mem_write;
        id_branch    <= branch;
        id_funct3    <= funct3;
        id_jal       <= jal;
        id_jalr      <= jalr;
    end

    x0_stays_zero: assert property (@(posedge clk) disable iff (rst)
        (wb_we && wb_rd == 5'd0 && rs1 == 5'd0) |=> (id_rs1_data == '0))
        else $error("x0 read back nonzero after a write to x0");

endmodule

/* hdl/execute_stage.sv */
`timescale 1ns/1ps
`include "core_params.svh"

module execute_stage
    import core_pkg::*;
(
    input  logic             clk,
    input  logic             rst,
    input  logic             id_valid,
    input  logic [`XLEN-1:0] id_pc,
    input  logic [`XLEN-1:0] id_rs1_data,
    input  logic [`XLEN-1:0] id_rs2_data,
    input  logic [`XLEN-1:0] id_imm,
    input  logic [4:0]       id_rs1,
    input  logic [4:0]       id_rs2,
    input  logic [4:0]       id_rd,
    input  alu_op_t          id_alu_op,
    input  logic             id_use_imm,
    input  logic             id_use_pc,
    input  logic             id_reg_write,
    input  logic             id_mem_read,
    input  logic             id_mem_write,
    input  logic             id_branch,
    input  logic [2:0]       id_funct3,
    input  logic             id_jal,
    input  logic             id_jalr,
    input  logic [4:0]       mem_rd,
    input  logic             mem_reg_write,
    input  logic [`XLEN-1:0] mem_result,
    input  logic [4:0]       wb_rd,
    input  logic             wb_we,
    input  logic [`XLEN-1:0] wb_data,
    output logic             flush,
    output logic [`XLEN-1:0] flush_target,
    output logic             ex_valid,
    output logic [`XLEN-1:0] ex_result,
    output logic [`XLEN-1:0] ex_store_data,
    output logic [4:0]       ex_rd,
    output logic             ex_reg_write,
    output logic             ex_mem_read,
    output logic             ex_mem_write
);

    logic [`XLEN-1:0] rs1_val;
    logic [`XLEN-1:0] rs2_val;
    logic [`XLEN-1:0] op_a;
    logic [`XLEN-1:0] op_b;
    logic [`XLEN-1:0] alu_out;
    logic             cond;

    // Newest producer wins
    function automatic logic [`XLEN-1:0] fwd(input logic [4:0] rs,
                                             input logic [`XLEN-1:0] rf_val);
        if (rs != 5'd0 && mem_reg_write && mem_rd == rs) begin
            return mem_result;
        end else if (rs != 5'd0 && wb_we && wb_rd == rs) begin
            return wb_data;
        end
        return rf_val;
    endfunction

    assign rs1_val = fwd(id_rs1, id_rs1_data);
    assign rs2_val = fwd(id_rs2, id_rs2_data);
    assign op_a    = id_use_pc ? id_pc : rs1_val;
    assign op_b    = id_use_imm ? id_imm : rs2_val;

    always_comb begin
        case (id_alu_op)
            ADD:     alu_out = op_a + op_b;
            SUB:     alu_out = op_a - op_b;
            AND:     alu_out = op_a & op_b;
            OR:      alu_out = op_a | op_b;
            XOR:     alu_out = op_a ^ op_b;
            SLL:     alu_out = op_a << op_b[4:0];
            SRL:     alu_out = op_a >> op_b[4:0];
            SRA:     alu_out = $signed(op_a) >>> op_b[4:0];
            SLT:     alu_out = `XLEN'($signed(op_a) < $signed(op_b));
            default: alu_out = op_b;
        endcase
    end

    always_comb begin
        case (id_funct3)
            3'b000:  cond = rs1_val == rs2_val;
            3'b001:  cond = rs1_val != rs2_val;
            3'b100:  cond = $signed(rs1_val) < $signed(rs2_val);
            3'b101:  cond = $signed(rs1_val) >= $signed(rs2_val);
            default: cond = 1'b0;
        endcase
    end

    assign flush = id_valid && ((id_branch && cond) || id_jal || id_jalr);
    assign flush_target = id_jalr ? ((rs1_val + id_imm) & {{(`XLEN-1){1'b1}}, 1'b0})
                                  : id_pc + id_imm;

    always_ff @(posedge clk) begin
        if (rst) begin
            ex_valid <= 1'b0;
        end else begin
            ex_valid <= id_valid;
        end
    end

    // Jumps carry the link value down the pipe
    always_ff @(posedge clk) begin
        ex_result     <= (id_jal || id_jalr) ? id_pc + `XLEN'(4) : alu_out;
        ex_store_data <= rs2_val;
        ex_rd         <= id_rd;
        ex_reg_write  <= id_reg_write;
        ex_mem_read   <= id_mem_read;
        ex_mem_write  <= id_mem_write;
    end

    // A flush also squashes what decode hands over next
    flush_squashes: assert property (@(posedge clk) disable iff (rst)
        flush |-> id_valid ##1 !id_valid)
        else $error("flush without a valid instruction, or younger one not squashed");

endmodule

/* hdl/memory_stage.sv */
`timescale 1ns/1ps
`include "core_params.svh"

module memory_stage (
    input  logic             clk,
    input  logic             rst,
    input  logic             ex_valid,
    input  logic [`XLEN-1:0] ex_result,
    input  logic [`XLEN-1:0] ex_store_data,
    input  logic [4:0]       ex_rd,
    input  logic             ex_reg_write,
    input  logic             ex_mem_read,
    input  logic             ex_mem_write,
    output logic [4:0]       mem_rd,
    output logic             mem_reg_write,
    output logic [`XLEN-1:0] mem_result,
    output logic             wb_we,
    output logic [4:0]       wb_rd,
    output logic [`XLEN-1:0] wb_data,
    output logic             st_valid,
    output logic [`XLEN-1:0] st_addr,
    output logic [`XLEN-1:0] st_data
);

    localparam int DA_W = $clog2(`DMEM_WORDS);

    logic [`XLEN-1:0] dmem [`DMEM_WORDS];
    logic [DA_W-1:0]  word_addr;
    logic             wb_valid;
    logic             wb_reg_write;
    logic             wb_load;
    logic [`XLEN-1:0] wb_alu;
    logic [`XLEN-1:0] wb_load_data;

    assign word_addr     = ex_result[DA_W+1:2];
    assign mem_rd        = ex_rd;
    assign mem_reg_write = ex_valid && ex_reg_write;
    assign mem_result    = ex_result;

    // Store observation
    assign st_valid = ex_valid && ex_mem_write;
    assign st_addr  = ex_result;
    assign st_data  = ex_store_data;

    always_ff @(posedge clk) begin
        if (ex_valid && ex_mem_write) begin
            dmem[word_addr] <= ex_store_data;
        end
        wb_load_data <= dmem[word_addr];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= ex_valid;
        end
    end

    always_ff @(posedge clk) begin
        wb_rd        <= ex_rd;
        wb_reg_write <= ex_reg_write;
        wb_load      <= ex_mem_read;
        wb_alu       <= ex_result;
    end

    assign wb_we   = wb_valid && wb_reg_write;
    assign wb_data = wb_load ? wb_load_data : wb_alu;

    addr_in_dmem: assert property (@(posedge clk) disable iff (rst)
        (ex_valid && (ex_mem_read || ex_mem_write)) |->
            (ex_result < 4 * `DMEM_WORDS && ex_result[1:0] == 2'b00))
        else $error("data access outside data memory at %h", ex_result);

endmodule

/* hdl/core_top.sv */
`timescale 1ns/1ps
`include "core_params.svh"

module core_top
    import core_pkg::*;
(
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           run,
    input  logic                           imem_we,
    input  logic [$clog2(`IMEM_WORDS)-1:0] imem_addr,
    input  logic [`XLEN-1:0]               imem_data,
    output logic                           st_valid,
    output logic [`XLEN-1:0]               st_addr,
    output logic [`XLEN-1:0]               st_data
);

    logic             if_valid;
    logic [`XLEN-1:0] if_pc;
    logic [`XLEN-1:0] if_inst;
    logic             stall;
    logic             flush;
    logic [`XLEN-1:0] flush_target;

    logic             id_valid;
    logic [`XLEN-1:0] id_pc;
    logic [`XLEN-1:0] id_rs1_data;
    logic [`XLEN-1:0] id_rs2_data;
    logic [`XLEN-1:0] id_imm;
    logic [4:0]       id_rs1;
    logic [4:0]       id_rs2;
    logic [4:0]       id_rd;
    alu_op_t          id_alu_op;
    logic             id_use_imm;
    logic             id_use_pc;
    logic             id_reg_write;
    logic             id_mem_read;
    logic             id_mem_write;
    logic             id_branch;
    logic [2:0]       id_funct3;
    logic             id_jal;
    logic             id_jalr;

    logic             ex_valid;
    logic [`XLEN-1:0] ex_result;
    logic [`XLEN-1:0] ex_store_data;
    logic [4:0]       ex_rd;
    logic             ex_reg_write;
    logic             ex_mem_read;
    logic             ex_mem_write;

    logic [4:0]       mem_rd;
    logic             mem_reg_write;
    logic [`XLEN-1:0] mem_result;
    logic             wb_we;
    logic [4:0]       wb_rd;
    logic [`XLEN-1:0] wb_data;

    fetch_stage u_fetch (
        .clk          (clk),
        .rst          (rst),
        .run          (run),
        .imem_we      (imem_we),
        .imem_addr    (imem_addr),
        .imem_data    (imem_data),
        .stall        (stall),
        .flush        (flush),
        .flush_target (flush_target),
        .if_valid     (if_valid),
        .if_pc        (if_pc),
        .if_inst      (if_inst)
    );

    decode_stage u_decode (
        .clk          (clk),
        .rst          (rst),
        .if_valid     (if_valid),
        .if_pc        (if_pc),
        .if_inst      (if_inst),
        .flush        (flush),
        .wb_we        (wb_we),
        .wb_rd        (wb_rd),
        .wb_data      (wb_data),
        .stall        (stall),
        .id_valid     (id_valid),
        .id_pc        (id_pc),
        .id_rs1_data  (id_rs1_data),
        .id_rs2_data  (id_rs2_data),
        .id_imm       (id_imm),
        .id_rs1       (id_rs1),
        .id_rs2       (id_rs2),
        .id_rd        (id_rd),
        .id_alu_op    (id_alu_op),
        .id_use_imm   (id_use_imm),
        .id_use_pc    (id_use_pc),
        .id_reg_write (id_reg_write),
        .id_mem_read  (id_mem_read),
        .id_mem_write (id_mem_write),
        .id_branch    (id_branch),
        .id_funct3    (id_funct3),
        .id_jal       (id_jal),
        .id_jalr      (id_jalr)
    );

    execute_stage u_execute (
        .clk           (clk),
        .rst           (rst),
        .id_valid      (id_valid),
        .id_pc         (id_pc),
        .id_rs1_data   (id_rs1_data),
        .id_rs2_data   (id_rs2_data),
        .id_imm        (id_imm),
        .id_rs1        (id_rs1),
        .id_rs2        (id_rs2),
        .id_rd         (id_rd),
        .id_alu_op     (id_alu_op),
        .id_use_imm    (id_use_imm),
        .id_use_pc     (id_use_pc),
        .id_reg_write  (id_reg_write),
        .id_mem_read   (id_mem_read),
        .id_mem_write  (id_mem_write),
        .id_branch     (id_branch),
        .id_funct3     (id_funct3),
        .id_jal        (id_jal),
        .id_jalr       (id_jalr),
        .mem_rd        (mem_rd),
        .mem_reg_write (mem_reg_write),
        .mem_result    (mem_result),
        .wb_rd         (wb_rd),
        .wb_we         (wb_we),
        .wb_data       (wb_data),
        .flush         (flush),
        .flush_target  (flush_target),
        .ex_valid      (ex_valid),
        .ex_result     (ex_result),
        .ex_store_data (ex_store_data),
        .ex_rd         (ex_rd),
        .ex_reg_write  (ex_reg_write),
        .ex_mem_read   (ex_mem_read),
        .ex_mem_write  (ex_mem_write)
    );

    memory_stage u_memory (
        .clk           (clk),
        .rst           (rst),
        .ex_valid      (ex_valid),
        .ex_result     (ex_result),
        .ex_store_data (ex_store_data),
        .ex_rd         (ex_rd),
        .ex_reg_write  (ex_reg_write),
        .ex_mem_read   (ex_mem_read),
        .ex_mem_write  (ex_mem_write),
        .mem_rd        (mem_rd),
        .mem_reg_write (mem_reg_write),
        .mem_result    (mem_result),
        .wb_we         (wb_we),
        .wb_rd         (wb_rd),
        .wb_data       (wb_data),
        .st_valid      (st_valid),
        .st_addr       (st_addr),
        .st_data       (st_data)
    );

endmodule

/* verif/core_prog.svh */
`ifndef CORE_PROG_SVH
`define CORE_PROG_SVH

localparam int PROG_WORDS = 39;
localparam int EXP_STORES = 13;

// addi x0, x0, 0
localparam logic [31:0] NOP = 32'h0000_0013;

localparam logic [31:0] PROG [PROG_WORDS] = '{
    32'h00500093,  // 0  addi x1, x0, 5
    32'h00A08113,  // 1  addi x2, x1, 10
    32'h002081B3,  // 2  add  x3, x1, x2
    32'h40118233,  // 3  sub  x4, x3, x1
    32'h0021F2B3,  // 4  and  x5, x3, x2
    32'h0012E333,  // 5  or   x6, x5, x1
    32'h003343B3,  // 6  xor  x7, x6, x3
    32'h00139433,  // 7  sll  x8, x7, x1
    32'h800004B7,  // 8  lui  x9, 0x80000
    32'h4014D533,  // 9  sra  x10, x9, x1
    32'h0014D5B3,  // 10 srl  x11, x9, x1
    32'h00152633,  // 11 slt  x12, x10, x1
    32'h00302023,  // 12 sw   x3, 0(x0)
    32'h00802223,  // 13 sw   x8, 4(x0)
    32'h00A02423,  // 14 sw   x10, 8(x0)
    32'h00B02623,  // 15 sw   x11, 12(x0)
    32'h00C02823,  // 16 sw   x12, 16(x0)
    32'h00702A23,  // 17 sw   x7, 20(x0)
    32'h00402C23,  // 18 sw   x4, 24(x0)
    32'h00602E23,  // 19 sw   x6, 28(x0)
    32'h00402683,  // 20 lw   x13, 4(x0)
    32'h00168733,  // 21 add  x14, x13, x1
    32'h02E02023,  // 22 sw   x14, 32(x0)
    32'h00108463,  // 23 beq  x1, x1, +8
    32'h02202223,  // 24 sw   x2, 36(x0)   sentinel
    32'h00209463,  // 25 bne  x1, x2, +8
    32'h02202423,  // 26 sw   x2, 40(x0)   sentinel
    32'h00114463,  // 27 blt  x2, x1, +8   not taken
    32'h02502623,  // 28 sw   x5, 44(x0)
    32'h008007EF,  // 29 jal  x15, +8
    32'h02202823,  // 30 sw   x2, 48(x0)   sentinel
    32'h02F02823,  // 31 sw   x15, 48(x0)
    32'h00C0086F,  // 32 jal  x16, +12
    32'h03002A23,  // 33 sw   x16, 52(x0)
    32'h00C0006F,  // 34 jal  x0, +12
    32'h00900893,  // 35 addi x17, x0, 9
    32'h00080067,  // 36 jalr x0, 0(x16)
    32'h03102C23,  // 37 sw   x17, 56(x0)
    32'h0000006F   // 38 jal  x0, 0
};

// Expected stores in program order
localparam logic [31:0] EXP_ADDR [EXP_STORES] = '{
    32'd0, 32'd4, 32'd8, 32'd12, 32'd16, 32'd20, 32'd24,
    32'd28, 32'd32, 32'd44, 32'd48, 32'd52, 32'd56
};

localparam logic [31:0] EXP_DATA [EXP_STORES] = '{
    32'd20,          // 5 + 15
    32'd544,         // 17 << 5
    32'hFC00_0000,   // 0x80000000 >>> 5
    32'h0400_0000,   // 0x80000000 >> 5
    32'd1,           // negative < 5
    32'd17,          // 5 ^ 20
    32'd15,          // 20 - 5
    32'd5,           // 4 | 5
    32'd549,         // loaded 544 + 5
    32'd4,           // 20 & 15
    32'd120,         // link of jal at 116
    32'd132,         // link of jal at 128
    32'd9
};

`endif

/* verif/core_tb.sv */
`timescale 1ns/1ps
`include "core_params.svh"

module core_tb;

    `include "core_prog.svh"

    logic                           clk;
    logic                           rst;
    logic                           run;
    logic                           imem_we;
    logic [$clog2(`IMEM_WORDS)-1:0] imem_addr;
    logic [`XLEN-1:0]               imem_data;
    logic                           st_valid;
    logic [`XLEN-1:0]               st_addr;
    logic [`XLEN-1:0]               st_data;

    int               exp_idx;
    logic [`XLEN-1:0] exp_cur_addr;
    logic [`XLEN-1:0] exp_cur_data;

    core_top uut (
        .clk       (clk),
        .rst       (rst),
        .run       (run),
        .imem_we   (imem_we),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .st_valid  (st_valid),
        .st_addr   (st_addr),
        .st_data   (st_data)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("SOME TESTS FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        string line;
        line = $sformatf("ERR %0t %s expected %h actual %h", $time, name, exp, act);
        stop_with_failure(line);
    endtask

    assign exp_cur_addr = (exp_idx < EXP_STORES) ? EXP_ADDR[exp_idx] : '0;
    assign exp_cur_data = (exp_idx < EXP_STORES) ? EXP_DATA[exp_idx] : '0;

    // Advance through the expected list on each store beat
    always @(negedge clk) begin
        if (rst) begin
            exp_idx <= 0;
        end else if (st_valid) begin
            exp_idx <= exp_idx + 1;
        end
    end

    quiet_while_loading: assert property (@(negedge clk) disable iff (rst)
        !run |-> !st_valid)
        else stop_with_failure("a store appeared while the program was loading");

    no_extra_store: assert property (@(negedge clk) disable iff (rst)
        st_valid |-> exp_idx < EXP_STORES)
        else stop_with_failure("a store appeared after all expected stores");

    store_addr_ok: assert property (@(negedge clk) disable iff (rst)
        (st_valid && exp_idx < EXP_STORES) |-> st_addr == exp_cur_addr)
        else report_mismatch("st_addr", $sampled(exp_cur_addr), $sampled(st_addr));

    store_data_ok: assert property (@(negedge clk) disable iff (rst)
        (st_valid && exp_idx < EXP_STORES) |-> st_data == exp_cur_data)
        else report_mismatch("st_data", $sampled(exp_cur_data), $sampled(st_data));

    initial begin
        rst       = 1'b1;
        run       = 1'b0;
        imem_we   = 1'b0;
        imem_addr = '0;
        imem_data = '0;
        repeat (5) @(posedge clk);
        #1 rst = 1'b0;

        // Unused words hold NOPs so fetch past the end stays defined
        for (int i = 0; i < `IMEM_WORDS; i++) begin
            @(posedge clk);
            #1;
            imem_we   = 1'b1;
            imem_addr = i[$clog2(`IMEM_WORDS)-1:0];
            imem_data = (i < PROG_WORDS) ? PROG[i] : NOP;
        end
        @(posedge clk);
        #1;
        imem_we = 1'b0;
        run     = 1'b1;

        while (exp_idx < EXP_STORES) begin
            @(posedge clk);
        end
        repeat (20) @(posedge clk);

        $display("ALL TESTS PASSED");
        $finish;
    end

    // Watchdog
    initial begin
        wait (run === 1'b1);
        #((PROG_WORDS + 40) * 100);
        stop_with_failure($sformatf("timeout, only %0d of %0d stores arrived",
                                    exp_idx, EXP_STORES));
    end

endmodule

/* core.f */
+incdir+hdl
+incdir+verif
hdl/core_pkg.sv
hdl/fetch_stage.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/memory_stage.sv
hdl/core_top.sv
verif/core_tb.sv

/* Makefile */
.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f core.f --top-module core_tb -o Vcore_tb

run: build
	-./obj_dir/Vcore_tb > sim.log 2>&1
	@cat sim.log
	@if grep -q "SOME TESTS FAILED" sim.log; then exit 1; fi
	@grep -q "ALL TESTS PASSED" sim.log

lint:
	verilator --lint-only --timing -Wall -f core.f --top-module core_top

clean:
	rm -rf obj_dir sim.log
